//--- source/rv32Pkg.sv
package rv32Pkg;

	localparam int dataWidth = 32;
	localparam int regIndexWidth = 5;

	// Major opcodes
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opOpImm = 7'b0010011;
	localparam logic [6:0] opOp = 7'b0110011;

	// ALU selectors
	localparam logic [2:0] funct3Add = 3'b000;
	localparam logic [2:0] funct3Sll = 3'b001;
	localparam logic [2:0] funct3Slt = 3'b010;
	localparam logic [2:0] funct3Sltu = 3'b011;
	localparam logic [2:0] funct3Xor = 3'b100;
	localparam logic [2:0] funct3Sr = 3'b101;
	localparam logic [2:0] funct3Or = 3'b110;
	localparam logic [2:0] funct3And = 3'b111;

	// SUB and SRA
	localparam logic [6:0] altFunct7 = 7'b0100000;

	// Management map, region in address bits 15:14
	localparam logic [1:0] regionSystem = 2'b00;
	localparam logic [1:0] regionRegisters = 2'b01;
	localparam logic [9:0] sysPc = 10'h000;
	localparam logic [9:0] sysInstruction = 10'h001;
	localparam logic [3:0] pcSetOffset = 4'h0;
	localparam logic [3:0] pcJumpOffset = 4'h4;
	localparam logic [3:0] pcStepOffset = 4'h8;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} iType;
	} instruction_u;

endpackage

//--- source/pipeControl.sv
`timescale 1ns/1ps

module pipeControl #(
	parameter logic [rv32Pkg::dataWidth-1:0] resetVector = '0
) (
	input logic clk,
	input logic rst,
	input logic managementRun,
	input logic pcSet,
	input logic pcJump,
	input logic pcStep,
	input logic [rv32Pkg::dataWidth-1:0] managementWriteData,
	input logic [rv32Pkg::dataWidth-1:0] executePc,
	input logic pipeActive,
	input logic instructionBusy,
	output logic [rv32Pkg::dataWidth-1:0] instructionAddress,
	output logic instructionEnable,
	output logic stepPipe,
	output logic haltedState
);

	localparam logic stateHalt = 1'b0;
	localparam logic stateExecute = 1'b1;

	logic state;
	logic stepPending;
	logic fetchAllowed;
	logic fetchStep;
	logic [rv32Pkg::dataWidth-1:0] fetchPc;

	assign fetchAllowed = managementRun || stepPending;
	assign instructionEnable = (state == stateExecute) && fetchAllowed;

	// Memory busy only blocks when a fetch is outstanding
	assign stepPipe = (state == stateExecute) && !(instructionEnable && instructionBusy);
	assign fetchStep = stepPipe && instructionEnable;

	assign instructionAddress = fetchPc;
	assign haltedState = (state == stateHalt);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalt;
		end else begin
			case (state)
				stateHalt: begin
					if (managementRun || pcStep) begin
						state <= stateExecute;
					end
				end
				stateExecute: begin
					// Drain until no stage holds a valid instruction
					if (!fetchAllowed && !pipeActive) begin
						state <= stateHalt;
					end
				end
				default: state <= stateHalt;
			endcase
		end
	end

	// One fetch per step request
	always_ff @(posedge clk) begin
		if (rst) begin
			stepPending <= 1'b0;
		end else if (pcStep) begin
			stepPending <= 1'b1;
		end else if (fetchStep) begin
			stepPending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetchPc <= resetVector;
		end else if (state == stateHalt) begin
			if (pcSet) begin
				fetchPc <= managementWriteData;
			end else if (pcJump) begin
				fetchPc <= executePc + managementWriteData;
			end
		end else if (fetchStep) begin
			fetchPc <= fetchPc + 'd4;
		end
	end

endmodule

//--- source/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
	input logic clk,
	input logic rst,
	input logic stepPipe,
	input logic instructionEnable,
	input logic [rv32Pkg::dataWidth-1:0] instructionData,
	input logic [rv32Pkg::dataWidth-1:0] instructionAddress,
	output logic fetchValid,
	output rv32Pkg::instruction_u fetchInstruction,
	output logic [rv32Pkg::dataWidth-1:0] fetchPc
);

	logic capture;

	assign capture = stepPipe && instructionEnable;

	// A step without a fetch leaves a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchValid <= 1'b0;
		end else if (stepPipe) begin
			fetchValid <= instructionEnable;
		end
	end

	// Kept after the pipe drains for management reads
	always_ff @(posedge clk) begin
		if (capture) begin
			fetchInstruction <= instructionData;
		end
	end

	// Execute PC, also seen on the probe
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchPc <= '0;
		end else if (capture) begin
			fetchPc <= instructionAddress;
		end
	end

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rst,
	input logic stepPipe,
	input logic fetchValid,
	input rv32Pkg::instruction_u fetchInstruction,
	input logic [rv32Pkg::dataWidth-1:0] rs1Data,
	input logic [rv32Pkg::dataWidth-1:0] rs2Data,
	output logic [rv32Pkg::regIndexWidth-1:0] rs1Index,
	output logic [rv32Pkg::regIndexWidth-1:0] rs2Index,
	output logic wbValid,
	output logic [rv32Pkg::regIndexWidth-1:0] wbRd,
	output logic [rv32Pkg::dataWidth-1:0] wbData
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [rv32Pkg::regIndexWidth-1:0] rd;
	logic isLui;
	logic isOpImm;
	logic isOp;
	logic isShift;
	logic altSelect;
	logic funct7Ok;
	logic subtract;
	logic recognized;
	logic [rv32Pkg::dataWidth-1:0] immediate;
	logic [rv32Pkg::dataWidth-1:0] operandB;
	logic [4:0] shiftAmount;
	logic [rv32Pkg::dataWidth-1:0] aluResult;
	logic [rv32Pkg::dataWidth-1:0] result;

	assign opcode = fetchInstruction.iType.opcode;
	assign funct3 = fetchInstruction.iType.funct3;
	assign rd = fetchInstruction.iType.rd;
	assign rs1Index = fetchInstruction.rType.rs1;
	assign rs2Index = fetchInstruction.rType.rs2;

	assign isLui = opcode == rv32Pkg::opLui;
	assign isOpImm = opcode == rv32Pkg::opOpImm;
	assign isOp = opcode == rv32Pkg::opOp;
	assign isShift = funct3 == rv32Pkg::funct3Sll || funct3 == rv32Pkg::funct3Sr;
	assign altSelect = fetchInstruction.rType.funct7 == rv32Pkg::altFunct7;

	// Alternate encoding only legal for SRA/SRAI and SUB
	assign funct7Ok = fetchInstruction.rType.funct7 == '0
		|| (altSelect && (funct3 == rv32Pkg::funct3Sr || (isOp && funct3 == rv32Pkg::funct3Add)));
	assign subtract = isOp && altSelect;

	// funct7 is immediate payload for non-shift OP-IMM
	assign recognized = isLui || (isOpImm && (!isShift || funct7Ok)) || (isOp && funct7Ok);

	assign immediate = {{(rv32Pkg::dataWidth-12){fetchInstruction.iType.imm12[11]}},
		fetchInstruction.iType.imm12};
	assign operandB = isOpImm ? immediate : rs2Data;
	assign shiftAmount = isOpImm ? fetchInstruction.iType.imm12[4:0] : rs2Data[4:0];

	always_comb begin
		aluResult = '0;
		case (funct3)
			rv32Pkg::funct3Add: begin
				if (subtract) begin
					aluResult = rs1Data - operandB;
				end else begin
					aluResult = rs1Data + operandB;
				end
			end
			rv32Pkg::funct3Sll: aluResult = rs1Data << shiftAmount;
			rv32Pkg::funct3Slt: aluResult[0] = $signed(rs1Data) < $signed(operandB);
			rv32Pkg::funct3Sltu: aluResult[0] = rs1Data < operandB;
			rv32Pkg::funct3Xor: aluResult = rs1Data ^ operandB;
			rv32Pkg::funct3Sr: begin
				if (altSelect) begin
					aluResult = $signed(rs1Data) >>> shiftAmount;
				end else begin
					aluResult = rs1Data >> shiftAmount;
				end
			end
			rv32Pkg::funct3Or: aluResult = rs1Data | operandB;
			rv32Pkg::funct3And: aluResult = rs1Data & operandB;
			default: aluResult = '0;
		endcase
	end

	// U-type immediate from the top 20 bits
	assign result = isLui ? {fetchInstruction[31:12], 12'h000} : aluResult;

	always_ff @(posedge clk) begin
		if (rst) begin
			wbValid <= 1'b0;
		end else if (stepPipe) begin
			wbValid <= fetchValid && recognized && (rd != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (stepPipe) begin
			wbRd <= rd;
			wbData <= result;
		end
	end

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic stepPipe,
	input logic wbValid,
	input logic [rv32Pkg::regIndexWidth-1:0] wbRd,
	input logic [rv32Pkg::dataWidth-1:0] wbData,
	input logic [rv32Pkg::regIndexWidth-1:0] rs1Index,
	input logic [rv32Pkg::regIndexWidth-1:0] rs2Index,
	input logic [rv32Pkg::regIndexWidth-1:0] readIndex,
	output logic [rv32Pkg::dataWidth-1:0] rs1Data,
	output logic [rv32Pkg::dataWidth-1:0] rs2Data,
	output logic [rv32Pkg::dataWidth-1:0] readData
);

	// x0 has no storage
	logic [rv32Pkg::dataWidth-1:0] registers [1:31];

	function automatic logic [rv32Pkg::dataWidth-1:0] readEntry(
		input logic [rv32Pkg::regIndexWidth-1:0] index
	);
		if (index == '0) begin
			return '0;
		end
		return registers[index];
	endfunction

	function automatic logic [rv32Pkg::dataWidth-1:0] forwardEntry(
		input logic [rv32Pkg::regIndexWidth-1:0] index
	);
		if (wbValid && index != '0 && wbRd == index) begin
			return wbData;
		end
		return readEntry(index);
	endfunction

	always_ff @(posedge clk) begin
		if (stepPipe && wbValid && wbRd != '0) begin
			registers[wbRd] <= wbData;
		end
	end

	// Writeback bypass into execute
	assign rs1Data = forwardEntry(rs1Index);
	assign rs2Data = forwardEntry(rs2Index);

	assign readData = readEntry(readIndex);

endmodule

//--- source/managementPort.sv
`timescale 1ns/1ps

module managementPort (
	input logic managementRun,
	input logic managementWriteEnable,
	input logic [3:0] managementByteSelect,
	input logic [15:0] managementAddress,
	input logic [rv32Pkg::dataWidth-1:0] fetchPc,
	input rv32Pkg::instruction_u fetchInstruction,
	input logic [rv32Pkg::dataWidth-1:0] registerData,
	output logic pcSet,
	output logic pcJump,
	output logic pcStep,
	output logic [rv32Pkg::regIndexWidth-1:0] readIndex,
	output logic [rv32Pkg::dataWidth-1:0] managementReadData
);

	logic selectPc;
	logic selectInstruction;
	logic selectRegister;
	logic writeValid;
	logic readValid;
	logic [rv32Pkg::dataWidth-1:0] selectedData;

	assign selectPc = managementAddress[15:14] == rv32Pkg::regionSystem
		&& managementAddress[13:4] == rv32Pkg::sysPc;
	assign selectInstruction = managementAddress[15:14] == rv32Pkg::regionSystem
		&& managementAddress[13:4] == rv32Pkg::sysInstruction;
	assign selectRegister = managementAddress[15:14] == rv32Pkg::regionRegisters
		&& managementAddress[13:7] == '0;

	// Port only acts while the core is not running
	assign writeValid = !managementRun && managementWriteEnable;
	assign readValid = !managementRun && !managementWriteEnable;

	assign pcSet = writeValid && selectPc && managementAddress[3:0] == rv32Pkg::pcSetOffset;
	assign pcJump = writeValid && selectPc && managementAddress[3:0] == rv32Pkg::pcJumpOffset;
	assign pcStep = writeValid && selectPc && managementAddress[3:0] == rv32Pkg::pcStepOffset;

	assign readIndex = managementAddress[rv32Pkg::regIndexWidth+1:2];

	always_comb begin
		if (readValid && selectPc) begin
			selectedData = fetchPc;
		end else if (readValid && selectInstruction) begin
			selectedData = fetchInstruction;
		end else if (readValid && selectRegister) begin
			selectedData = registerData;
		end else begin
			selectedData = '1;
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			managementReadData[8*i +: 8] = managementByteSelect[i] ? selectedData[8*i +: 8] : 8'h00;
		end
	end

endmodule

//--- source/rv32Core.sv
`timescale 1ns/1ps

module rv32Core #(
	parameter logic [rv32Pkg::dataWidth-1:0] resetVector = '0
) (
	input logic clk,
	input logic rst,
	output logic [rv32Pkg::dataWidth-1:0] instructionAddress,
	output logic instructionEnable,
	input logic [rv32Pkg::dataWidth-1:0] instructionData,
	input logic instructionBusy,
	input logic managementRun,
	input logic managementWriteEnable,
	input logic [3:0] managementByteSelect,
	input logic [15:0] managementAddress,
	input logic [rv32Pkg::dataWidth-1:0] managementWriteData,
	output logic [rv32Pkg::dataWidth-1:0] managementReadData,
	output logic probeState,
	output logic [rv32Pkg::dataWidth-1:0] probeProgramCounter
);

	logic stepPipe;
	logic haltedState;
	logic pipeActive;
	logic pcSet;
	logic pcJump;
	logic pcStep;
	logic fetchValid;
	rv32Pkg::instruction_u fetchInstruction;
	logic [rv32Pkg::dataWidth-1:0] fetchPc;
	logic [rv32Pkg::regIndexWidth-1:0] rs1Index;
	logic [rv32Pkg::regIndexWidth-1:0] rs2Index;
	logic [rv32Pkg::dataWidth-1:0] rs1Data;
	logic [rv32Pkg::dataWidth-1:0] rs2Data;
	logic wbValid;
	logic [rv32Pkg::regIndexWidth-1:0] wbRd;
	logic [rv32Pkg::dataWidth-1:0] wbData;
	logic [rv32Pkg::regIndexWidth-1:0] readIndex;
	logic [rv32Pkg::dataWidth-1:0] registerData;

	// Anything still in flight past fetch
	assign pipeActive = fetchValid || wbValid;

	assign probeState = !haltedState;
	assign probeProgramCounter = fetchPc;

	pipeControl #(
		.resetVector(resetVector)
	) i_pipeControl (
		.clk(clk),
		.rst(rst),
		.managementRun(managementRun),
		.pcSet(pcSet),
		.pcJump(pcJump),
		.pcStep(pcStep),
		.managementWriteData(managementWriteData),
		.executePc(fetchPc),
		.pipeActive(pipeActive),
		.instructionBusy(instructionBusy),
		.instructionAddress(instructionAddress),
		.instructionEnable(instructionEnable),
		.stepPipe(stepPipe),
		.haltedState(haltedState)
	);

	fetchStage i_fetchStage (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.instructionEnable(instructionEnable),
		.instructionData(instructionData),
		.instructionAddress(instructionAddress),
		.fetchValid(fetchValid),
		.fetchInstruction(fetchInstruction),
		.fetchPc(fetchPc)
	);

	executeStage i_executeStage (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.fetchValid(fetchValid),
		.fetchInstruction(fetchInstruction),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData)
	);

	registerFile i_registerFile (
		.clk(clk),
		.stepPipe(stepPipe),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.readIndex(readIndex),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.readData(registerData)
	);

	managementPort i_managementPort (
		.managementRun(managementRun),
		.managementWriteEnable(managementWriteEnable),
		.managementByteSelect(managementByteSelect),
		.managementAddress(managementAddress),
		.fetchPc(instructionAddress),
		.fetchInstruction(fetchInstruction),
		.registerData(registerData),
		.pcSet(pcSet),
		.pcJump(pcJump),
		.pcStep(pcStep),
		.readIndex(readIndex),
		.managementReadData(managementReadData)
	);

endmodule

//--- sim/rv32Core_chk.sv
`timescale 1ns/1ps

module rv32Core_chk (
	input logic clk,
	input logic rst,
	input logic haltedState,
	input logic instructionEnable,
	input logic stepPipe,
	input logic pcSet,
	input logic pcJump,
	input logic [rv32Pkg::dataWidth-1:0] instructionAddress
);

	noFetchInHalt: assert property (@(posedge clk) disable iff (rst)
		haltedState |-> !instructionEnable)
		else $error("instructionEnable high while halted");

	// Fetch PC only moves on a management write while halted
	pcStableInHalt: assert property (@(posedge clk) disable iff (rst)
		(haltedState && !pcSet && !pcJump) |=> $stable(instructionAddress))
		else $error("fetch PC changed in HALT without a management write");

	noStepInHalt: assert property (@(posedge clk) disable iff (rst)
		haltedState |-> !stepPipe)
		else $error("stepPipe high while halted");

endmodule

bind pipeControl rv32Core_chk i_rv32Core_chk (
	.clk(clk),
	.rst(rst),
	.haltedState(haltedState),
	.instructionEnable(instructionEnable),
	.stepPipe(stepPipe),
	.pcSet(pcSet),
	.pcJump(pcJump),
	.instructionAddress(instructionAddress)
);

//--- sim/rv32Core_tb.sv
`timescale 1ns/1ps

module rv32Core_tb;

	localparam logic [rv32Pkg::dataWidth-1:0] resetVector = 32'h0000_0040;
	localparam logic [rv32Pkg::dataWidth-1:0] stepBase = 32'h100;
	localparam logic [rv32Pkg::dataWidth-1:0] runBase = 32'h200;
	localparam logic [15:0] pcAddress = 16'h0000;
	localparam logic [15:0] jumpAddress = 16'h0004;
	localparam logic [15:0] stepAddress = 16'h0008;
	localparam logic [15:0] instructionReadAddress = 16'h0010;

	logic clk;
	logic rst;
	logic [rv32Pkg::dataWidth-1:0] instructionAddress;
	logic instructionEnable;
	logic [rv32Pkg::dataWidth-1:0] instructionData;
	logic instructionBusy;
	logic managementRun;
	logic managementWriteEnable;
	logic [3:0] managementByteSelect;
	logic [15:0] managementAddress;
	logic [rv32Pkg::dataWidth-1:0] managementWriteData;
	logic [rv32Pkg::dataWidth-1:0] managementReadData;
	logic probeState;
	logic [rv32Pkg::dataWidth-1:0] probeProgramCounter;

	logic [31:0] memory [0:255];
	logic [31:0] tableWord [$];
	logic [4:0] tableRd [$];
	logic [31:0] tableExpected [$];
	bit tableRun [$];
	logic [31:0] lfsrState = 32'hce75_a13e;
	logic busyBit = 1'b0;
	logic busyRandom;
	logic busyHold;
	int cycleCount = 0;
	int cycleLimit = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int testStartErrors = 0;

	rv32Core #(.resetVector(resetVector)) i_rv32Core (.*);

	// Memory answers in the same cycle
	assign instructionData = memory[instructionAddress[9:2]];
	assign instructionBusy = busyHold || (busyRandom && busyBit);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] nextLfsr(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// One LFSR step per busy bit
	always @(negedge clk) begin
		if (busyRandom) begin
			busyBit <= lfsrState[0];
			lfsrState <= nextLfsr(lfsrState);
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: the core did not halt within %0d cycles", cycleLimit);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv32Pkg::opOp};
	endfunction

	function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, rv32Pkg::opOpImm};
	endfunction

	function automatic logic [15:0] registerAddress(input logic [4:0] index);
		return {rv32Pkg::regionRegisters, 7'd0, index, 2'b00};
	endfunction

	task automatic addEntry(input logic [31:0] word, input logic [4:0] rd,
		input logic [31:0] expected, input bit isRun);
		tableWord.push_back(word);
		tableRd.push_back(rd);
		tableExpected.push_back(expected);
		tableRun.push_back(isRun);
	endtask

	task automatic checkWord(input string name, input logic [rv32Pkg::dataWidth-1:0] actual,
		input logic [rv32Pkg::dataWidth-1:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkBit(input string name, input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic managementWrite(input logic [15:0] address, input logic [31:0] data);
		@(negedge clk);
		managementWriteEnable = 1'b1;
		managementAddress = address;
		managementWriteData = data;
		@(negedge clk);
		managementWriteEnable = 1'b0;
	endtask

	task automatic managementRead(input logic [15:0] address, input logic [3:0] select,
		output logic [31:0] data);
		@(negedge clk);
		managementAddress = address;
		managementByteSelect = select;
		@(negedge clk);
		data = managementReadData;
	endtask

	task automatic waitHalt();
		while (probeState) begin
			@(negedge clk);
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("Test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
		testStartErrors = errorCount;
	endtask

	initial begin
		logic [31:0] readValue;
		logic [31:0] oldPc;
		logic [31:0] jumpBase;
		int runCount;
		int stepCount;
		rst = 1'b1;
		managementRun = 1'b0;
		managementWriteEnable = 1'b0;
		managementByteSelect = 4'hF;
		managementAddress = '0;
		managementWriteData = '0;
		busyRandom = 1'b0;
		busyHold = 1'b0;
		for (int i = 0; i < 256; i++) begin
			memory[i] = {i[7:0], ~i[7:0], i[7:0], 1'b0, 7'h7f};
		end
		addEntry({20'h80000, 5'd1, rv32Pkg::opLui}, 1, 32'h8000_0000, 0);
		addEntry(encodeI(12'd5, 0, rv32Pkg::funct3Add, 2), 2, 32'd5, 0);
		addEntry(encodeI(12'hFFD, 0, rv32Pkg::funct3Add, 3), 3, 32'hFFFF_FFFD, 0);
		addEntry(encodeI(12'd2, 3, rv32Pkg::funct3Slt, 4), 4, 32'd1, 0);
		addEntry(encodeI(12'd2, 3, rv32Pkg::funct3Sltu, 5), 5, 32'd0, 0);
		addEntry(encodeI(12'h0F0, 2, rv32Pkg::funct3Xor, 6), 6, 32'hF5, 0);
		addEntry(encodeI(12'h100, 2, rv32Pkg::funct3Or, 7), 7, 32'h105, 0);
		addEntry(encodeI(12'h0FF, 3, rv32Pkg::funct3And, 8), 8, 32'hFD, 0);
		addEntry(encodeI(12'h004, 2, rv32Pkg::funct3Sll, 9), 9, 32'h50, 0);
		addEntry(encodeI(12'h004, 1, rv32Pkg::funct3Sr, 10), 10, 32'h0800_0000, 0);
		addEntry(encodeI(12'h404, 1, rv32Pkg::funct3Sr, 11), 11, 32'hF800_0000, 0);
		addEntry(encodeR(7'h00, 3, 2, rv32Pkg::funct3Add, 12), 12, 32'd2, 0);
		addEntry(encodeR(rv32Pkg::altFunct7, 3, 2, rv32Pkg::funct3Add, 13), 13, 32'd8, 0);
		addEntry(encodeR(7'h00, 9, 2, rv32Pkg::funct3Sll, 14), 14, 32'h0005_0000, 0);
		addEntry(encodeR(7'h00, 2, 3, rv32Pkg::funct3Slt, 15), 15, 32'd1, 0);
		addEntry(encodeR(7'h00, 2, 3, rv32Pkg::funct3Sltu, 16), 16, 32'd0, 0);
		addEntry(encodeR(7'h00, 3, 1, rv32Pkg::funct3Xor, 17), 17, 32'h7FFF_FFFD, 0);
		addEntry(encodeR(7'h00, 2, 1, rv32Pkg::funct3Sr, 18), 18, 32'h0400_0000, 0);
		addEntry(encodeR(rv32Pkg::altFunct7, 2, 1, rv32Pkg::funct3Sr, 19), 19, 32'hFC00_0000, 0);
		addEntry(encodeR(7'h00, 9, 2, rv32Pkg::funct3Or, 20), 20, 32'h55, 0);
		addEntry(encodeR(7'h00, 7, 3, rv32Pkg::funct3And, 21), 21, 32'h105, 0);
		// x0 stays zero, and an unknown opcode with rd of x2 leaves it alone
		addEntry(encodeI(12'd7, 2, rv32Pkg::funct3Add, 0), 0, 32'd0, 0);
		addEntry({12'd9, 5'd2, 3'b000, 5'd2, 7'h7f}, 2, 32'd5, 0);
		// Back-to-back dependent program, opening with a write to x0 that x22 reads
		addEntry(encodeI(12'h055, 2, rv32Pkg::funct3Add, 0), 0, 32'd0, 1);
		addEntry(encodeI(12'h123, 0, rv32Pkg::funct3Add, 22), 22, 32'h123, 1);
		addEntry(encodeI(12'h008, 22, rv32Pkg::funct3Sll, 23), 23, 32'h1_2300, 1);
		addEntry(encodeR(7'h00, 22, 23, rv32Pkg::funct3Add, 24), 24, 32'h1_2423, 1);
		addEntry(encodeR(rv32Pkg::altFunct7, 22, 24, rv32Pkg::funct3Add, 25), 25, 32'h1_2300, 1);
		addEntry(encodeR(7'h00, 24, 25, rv32Pkg::funct3Xor, 26), 26, 32'h723, 1);
		cycleLimit = tableWord.size() * 40 + 200;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		checkBit("probeState", probeState, 1'b0);
		checkBit("instructionEnable", instructionEnable, 1'b0);
		managementRead(pcAddress, 4'hF, readValue);
		checkWord("pc", readValue, resetVector);
		managementRead(16'hC000, 4'hF, readValue);
		checkWord("unmapped read", readValue, 32'hFFFF_FFFF);
		finishTest("reset state");

		stepCount = 0;
		foreach (tableWord[i]) begin
			if (!tableRun[i]) begin
				oldPc = stepBase + 4 * stepCount;
				memory[oldPc[9:2]] = tableWord[i];
				managementWrite(pcAddress, oldPc);
				managementWrite(stepAddress, '0);
				waitHalt();
				managementRead(registerAddress(tableRd[i]), 4'hF, readValue);
				checkWord($sformatf("x%0d", tableRd[i]), readValue, tableExpected[i]);
				managementRead(pcAddress, 4'hF, readValue);
				checkWord("pc", readValue, oldPc + 4);
				managementRead(instructionReadAddress, 4'hF, readValue);
				checkWord("instruction", readValue, tableWord[i]);
				stepCount++;
			end
		end
		finishTest("single steps, x0 and unknown opcode");

		runCount = 0;
		foreach (tableWord[i]) begin
			if (tableRun[i]) begin
				memory[(runBase >> 2) + runCount] = tableWord[i];
				runCount++;
			end
		end
		managementWrite(pcAddress, runBase);
		busyRandom <= 1'b1;
		managementRun = 1'b1;
		@(negedge clk);
		checkBit("probeState", probeState, 1'b1);
		// Stop once the last word has been fetched
		while (instructionAddress !== runBase + 4 * runCount) begin
			@(negedge clk);
		end
		managementRun = 1'b0;
		busyRandom <= 1'b0;
		waitHalt();
		foreach (tableWord[i]) begin
			if (tableRun[i]) begin
				managementRead(registerAddress(tableRd[i]), 4'hF, readValue);
				checkWord($sformatf("x%0d", tableRd[i]), readValue, tableExpected[i]);
			end
		end
		finishTest("run with forwarding under random busy");

		// Execute PC holds the address of the last word fetched
		jumpBase = runBase + 4 * (runCount - 1);
		checkWord("probeProgramCounter", probeProgramCounter, jumpBase);
		managementWrite(jumpAddress, 32'h40);
		managementRead(pcAddress, 4'hF, readValue);
		checkWord("pc after jump", readValue, jumpBase + 32'h40);
		managementRead(registerAddress(17), 4'b0101, readValue);
		checkWord("x17 bytes 2 and 0", readValue, 32'h00FF_00FD);
		managementRead(registerAddress(17), 4'b1010, readValue);
		checkWord("x17 bytes 3 and 1", readValue, 32'h7F00_FF00);
		finishTest("jump and byte masking");

		// Busy held so no fetch moves the PC while running
		managementWrite(pcAddress, 32'h380);
		busyHold = 1'b1;
		managementRun = 1'b1;
		managementWrite(pcAddress, 32'h300);
		@(negedge clk);
		managementRun = 1'b0;
		busyHold = 1'b0;
		waitHalt();
		managementRead(pcAddress, 4'hF, readValue);
		checkWord("pc after write during run", readValue, 32'h380);
		finishTest("writes ignored while running");

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- src.f
source/rv32Pkg.sv
source/pipeControl.sv
source/fetchStage.sv
source/executeStage.sv
source/registerFile.sv
source/managementPort.sv
source/rv32Core.sv
sim/rv32Core_chk.sv
sim/rv32Core_tb.sv
